//--- source/soc_bus_pkg.sv
package soc_bus_pkg;

    // Memory map
    localparam logic [63:0] RAM_BASE     = 64'h0000_0000_0000_1000;
    localparam int          RAM_WORDS    = 1024;
    localparam logic [63:0] KEY_ADDR     = 64'h0000_0000_8000_0000;
    localparam logic [63:0] UART_ADDR    = 64'h0000_0000_8000_0008;
    localparam logic [63:0] SD_ADDR_REG  = 64'h0000_0000_8000_0010;
    localparam logic [63:0] SD_READ_REG  = 64'h0000_0000_8000_0018;
    localparam logic [63:0] SD_READY_REG = 64'h0000_0000_8000_0020;
    localparam logic [63:0] SD_AVAIL_REG = 64'h0000_0000_8000_0028;
    localparam logic [63:0] SD_BUF_BASE  = 64'h0000_0000_8000_1000;
    localparam int          SD_BUF_BYTES = 512;

    // Read latency in cycles, counted from rd_start
    localparam int LD_LATENCY    = 3;
    localparam int SHORT_LATENCY = 2;

    typedef enum logic [3:0] {
        REG_NONE,
        REG_RAM,
        REG_KEY,
        REG_UART,
        REG_SD_ADDR,
        REG_SD_READ,
        REG_SD_READY,
        REG_SD_AVAIL,
        REG_SD_BUF
    } region_e;

    // Same encoding as the core's bus_read_type
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LD  = 3'd3,
        LBU = 3'd4,
        LHU = 3'd5,
        LWU = 3'd6
    } load_e;

    typedef struct packed {
        logic        rd_start;
        logic        wr;
        logic        wr_edge;
        region_e     region;
        logic [9:0]  word_index;
        logic [8:0]  buf_index;
        logic [1:0]  byte_offset;
        load_e       load_type;
        logic [63:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        done;
        logic        from_ram;
        logic [1:0]  byte_offset;
        load_e       load_type;
        logic [63:0] data;
    } bus_resp_t;

endpackage

//--- source/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import soc_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic [63:0] bus_address,
    input  logic [63:0] bus_write_data,
    input  logic        bus_write_enable,
    input  logic        bus_read_enable,
    input  logic [2:0]  bus_read_type,
    output bus_req_t    req
);

    logic        re_d;
    logic        we_d;
    logic        rd_start_q;
    logic        wr_q;
    logic        wr_edge_q;
    region_e     region_c;
    region_e     region_q;
    logic [63:0] ram_off;
    logic [63:0] buf_off;
    logic [9:0]  word_q;
    logic [8:0]  buf_q;
    logic [1:0]  offset_q;
    load_e       type_q;
    logic [63:0] wdata_q;

    // Address to region
    always_comb begin
        ram_off  = bus_address - RAM_BASE;
        buf_off  = bus_address - SD_BUF_BASE;
        region_c = REG_NONE;
        if (bus_address >= RAM_BASE && bus_address < RAM_BASE + 64'(RAM_WORDS * 4)) begin
            region_c = REG_RAM;
        end else if (bus_address == KEY_ADDR) begin
            region_c = REG_KEY;
        end else if (bus_address == UART_ADDR) begin
            region_c = REG_UART;
        end else if (bus_address == SD_ADDR_REG) begin
            region_c = REG_SD_ADDR;
        end else if (bus_address == SD_READ_REG) begin
            region_c = REG_SD_READ;
        end else if (bus_address == SD_READY_REG) begin
            region_c = REG_SD_READY;
        end else if (bus_address == SD_AVAIL_REG) begin
            region_c = REG_SD_AVAIL;
        end else if (bus_address >= SD_BUF_BASE &&
                     bus_address < SD_BUF_BASE + 64'(SD_BUF_BYTES)) begin
            region_c = REG_SD_BUF;
        end
    end

    // Strobes and edge detection
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            re_d       <= 1'b0;
            we_d       <= 1'b0;
            rd_start_q <= 1'b0;
            wr_q       <= 1'b0;
            wr_edge_q  <= 1'b0;
        end else begin
            re_d       <= bus_read_enable;
            we_d       <= bus_write_enable;
            rd_start_q <= bus_read_enable && !re_d;
            wr_q       <= bus_write_enable;
            wr_edge_q  <= bus_write_enable && !we_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        region_q <= region_c;
        word_q   <= ram_off[11:2];
        buf_q    <= buf_off[8:0];
        offset_q <= bus_address[1:0];
        type_q   <= load_e'(bus_read_type);
        wdata_q  <= bus_write_data;
    end

    always_comb begin
        req.rd_start    = rd_start_q;
        req.wr          = wr_q;
        req.wr_edge     = wr_edge_q;
        req.region      = region_q;
        req.word_index  = word_q;
        req.buf_index   = buf_q;
        req.byte_offset = offset_q;
        req.load_type   = type_q;
        req.wdata       = wdata_q;
    end

    // The core never reads and writes at once
    a_no_read_write: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

endmodule

//--- source/ram_port.sv
`timescale 1ns/1ps

module ram_port import soc_bus_pkg::*; (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  bus_req_t  req,
    output bus_resp_t resp
);

    typedef enum logic {
        IDLE,
        SECOND_BEAT
    } state_e;

    state_e      state;
    logic [31:0] mem [0:RAM_WORDS-1];
    logic [31:0] rd_word;
    logic [31:0] lo_word;
    logic [9:0]  hi_index;
    logic [9:0]  rd_addr;
    logic [1:0]  offset_q;
    load_e       type_q;
    logic        done_q;
    logic        ram_rd;
    logic        ram_wr;

    assign ram_rd = req.rd_start && req.region == REG_RAM;
    assign ram_wr = req.wr && req.region == REG_RAM;

    // Second ld beat reads the next word
    always_comb begin
        rd_addr = (state == SECOND_BEAT) ? hi_index : req.word_index;
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_wr) begin
            mem[req.word_index] <= req.wdata[31:0];
        end
        rd_word <= mem[rd_addr];
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_rd) begin
            hi_index <= req.word_index + 10'd1;
            offset_q <= req.byte_offset;
            type_q   <= req.load_type;
        end
        if (state == SECOND_BEAT) begin
            lo_word <= rd_word;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state  <= IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (ram_rd) begin
                        if (req.load_type == LD) begin
                            state <= SECOND_BEAT;
                        end else begin
                            done_q <= 1'b1;
                        end
                    end
                end
                SECOND_BEAT: begin
                    done_q <= 1'b1;
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Low word first, high word in the upper half
    always_comb begin
        resp.done        = done_q;
        resp.from_ram    = 1'b1;
        resp.byte_offset = offset_q;
        resp.load_type   = type_q;
        resp.data        = (type_q == LD) ? {rd_word, lo_word} : {32'd0, rd_word};
    end

    a_done_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        resp.done |=> !resp.done);

    a_ld_two_beats: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (ram_rd && req.load_type == LD) |-> ##2 resp.done);

endmodule

//--- source/periph_regs.sv
`timescale 1ns/1ps

module periph_regs import soc_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  bus_req_t    req,
    input  logic [7:0]  key_ascii,
    input  logic        key_pressed,
    input  logic        interrupt_ack,
    input  logic [7:0]  sd_byte,
    input  logic        sd_byte_available,
    input  logic        sd_ready,
    output bus_resp_t   resp,
    output logic [3:0]  interrupt_vector,
    output logic [7:0]  uart_data,
    output logic        uart_write,
    output logic [31:0] sd_addr,
    output logic        sd_rd_start
);

    logic        key_d;
    logic        key_edge;
    logic [7:0]  key_reg;
    logic        byte_d;
    logic        byte_edge;
    logic [7:0]  sd_buf [0:SD_BUF_BYTES-1];
    logic [8:0]  byte_index;
    logic        sd_full;
    logic        uart_sel;
    logic        sd_addr_sel;
    logic        sd_read_sel;
    logic        done_q;
    logic [63:0] rdata;

    assign key_edge    = key_pressed && !key_d;
    assign byte_edge   = sd_byte_available && !byte_d;
    assign uart_sel    = req.wr && req.region == REG_UART;
    assign sd_addr_sel = req.wr && req.region == REG_SD_ADDR;
    assign sd_read_sel = req.wr && req.region == REG_SD_READ;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_d            <= 1'b0;
            key_reg          <= 8'd0;
            interrupt_vector <= 4'd0;
            byte_d           <= 1'b0;
            byte_index       <= 9'd0;
            sd_full          <= 1'b0;
            uart_write       <= 1'b0;
            sd_rd_start      <= 1'b0;
            done_q           <= 1'b0;
        end else begin
            key_d  <= key_pressed;
            byte_d <= sd_byte_available;

            // Keyboard interrupt, ack wins over a new press
            if (key_edge) begin
                key_reg <= key_ascii;
                if (key_ascii != 8'd0) begin
                    interrupt_vector <= 4'd1;
                end
            end
            if (interrupt_ack) begin
                interrupt_vector <= 4'd0;
            end

            // One strobe per write burst
            uart_write  <= uart_sel && req.wr_edge;
            sd_rd_start <= sd_read_sel && req.wr_edge;

            if (sd_read_sel) begin
                byte_index <= 9'd0;
                sd_full    <= 1'b0;
            end else if (byte_edge) begin
                byte_index <= byte_index + 9'd1;
                if (byte_index == 9'(SD_BUF_BYTES - 1)) begin
                    sd_full <= 1'b1;
                end
            end

            // Everything outside the RAM answers here, unmapped too
            done_q <= req.rd_start && req.region != REG_RAM;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (uart_sel) begin
            uart_data <= req.wdata[7:0];
        end
        if (sd_addr_sel) begin
            sd_addr <= req.wdata[31:0];
        end
        if (byte_edge) begin
            sd_buf[byte_index] <= sd_byte;
        end
        if (req.rd_start) begin
            case (req.region)
                REG_KEY:      rdata <= {56'd0, key_reg};
                REG_UART:     rdata <= {56'd0, uart_data};
                REG_SD_ADDR:  rdata <= {32'd0, sd_addr};
                REG_SD_READY: rdata <= {63'd0, sd_ready};
                REG_SD_AVAIL: rdata <= {63'd0, sd_full};
                REG_SD_BUF:   rdata <= {56'd0, sd_buf[req.buf_index]};
                default:      rdata <= 64'd0;
            endcase
        end
    end

    // Register values are already zero-extended
    always_comb begin
        resp.done        = done_q;
        resp.from_ram    = 1'b0;
        resp.byte_offset = 2'd0;
        resp.load_type   = LD;
        resp.data        = rdata;
    end

    a_uart_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |=> !uart_write);

    a_sd_start_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start);

endmodule

//--- source/read_return.sv
`timescale 1ns/1ps

module read_return import soc_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  bus_resp_t   ram_resp,
    input  bus_resp_t   periph_resp,
    input  bus_req_t    req,
    output logic [63:0] bus_read_data,
    output logic        bus_read_done,
    output logic [7:0]  debug_led
);

    bus_resp_t   sel;
    logic [63:0] shifted;
    logic [63:0] ext;
    logic        any_done;
    logic        ram_ld;

    assign any_done = ram_resp.done || periph_resp.done;
    assign ram_ld   = req.rd_start && req.region == REG_RAM && req.load_type == LD;

    // Align and extend RAM data
    always_comb begin
        sel     = ram_resp.done ? ram_resp : periph_resp;
        shifted = sel.data >> {sel.byte_offset, 3'b000};
        ext     = sel.data;
        if (sel.from_ram) begin
            case (sel.load_type)
                LB:      ext = {{56{shifted[7]}}, shifted[7:0]};
                LH:      ext = {{48{shifted[15]}}, shifted[15:0]};
                LW:      ext = {{32{shifted[31]}}, shifted[31:0]};
                LBU:     ext = {56'd0, shifted[7:0]};
                LHU:     ext = {48'd0, shifted[15:0]};
                LWU:     ext = {32'd0, shifted[31:0]};
                default: ext = sel.data;
            endcase
        end
    end

    // Data held until the next done
    always_ff @(posedge CLOCK_50) begin
        if (any_done) begin
            bus_read_data <= ext;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b0;
            debug_led     <= 8'd0;
        end else begin
            bus_read_done <= any_done;
            // Low nibble is the last region, bit 5 marks a write
            if (req.rd_start || (req.wr && req.wr_edge)) begin
                debug_led[3:0] <= req.region;
                debug_led[5]   <= req.wr;
            end
            if (any_done) begin
                debug_led[4] <= (ext == 64'd0);
                debug_led[6] <= sel.from_ram;
                debug_led[7] <= sel.from_ram && sel.load_type == LD;
            end
        end
    end

    a_ld_latency: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ram_ld |-> ##LD_LATENCY bus_read_done);

    a_short_latency: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (req.rd_start && !ram_ld) |-> ##SHORT_LATENCY bus_read_done);

endmodule

//--- source/soc_bus.sv
`timescale 1ns/1ps

module soc_bus import soc_bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    // Core side
    input  logic [63:0] bus_address,
    input  logic [63:0] bus_write_data,
    input  logic        bus_write_enable,
    input  logic        bus_read_enable,
    input  logic [2:0]  bus_read_type,
    output logic [63:0] bus_read_data,
    output logic        bus_read_done,
    // Board side
    input  logic [7:0]  key_ascii,
    input  logic        key_pressed,
    input  logic        interrupt_ack,
    input  logic [7:0]  sd_byte,
    input  logic        sd_byte_available,
    input  logic        sd_ready,
    output logic [3:0]  interrupt_vector,
    output logic [7:0]  uart_data,
    output logic        uart_write,
    output logic [31:0] sd_addr,
    output logic        sd_rd_start,
    output logic [7:0]  debug_led
);

    bus_req_t  req;
    bus_resp_t ram_resp;
    bus_resp_t periph_resp;

    bus_decoder decoder_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_type    (bus_read_type),
        .req              (req)
    );

    ram_port ram_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (req),
        .resp     (ram_resp)
    );

    periph_regs periph_i (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .req               (req),
        .key_ascii         (key_ascii),
        .key_pressed       (key_pressed),
        .interrupt_ack     (interrupt_ack),
        .sd_byte           (sd_byte),
        .sd_byte_available (sd_byte_available),
        .sd_ready          (sd_ready),
        .resp              (periph_resp),
        .interrupt_vector  (interrupt_vector),
        .uart_data         (uart_data),
        .uart_write        (uart_write),
        .sd_addr           (sd_addr),
        .sd_rd_start       (sd_rd_start)
    );

    read_return return_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .ram_resp      (ram_resp),
        .periph_resp   (periph_resp),
        .req           (req),
        .bus_read_data (bus_read_data),
        .bus_read_done (bus_read_done),
        .debug_led     (debug_led)
    );

endmodule

//--- tb/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

    // Board memory map and latencies as seen from the core
    localparam logic [63:0] RAM_LO      = 64'h1000;
    localparam logic [63:0] RAM_HI      = 64'h2000;
    localparam logic [63:0] KEY_REG     = 64'h8000_0000;
    localparam logic [63:0] UART_REG    = 64'h8000_0008;
    localparam logic [63:0] SD_ADDR_R   = 64'h8000_0010;
    localparam logic [63:0] SD_READ_R   = 64'h8000_0018;
    localparam logic [63:0] SD_READY_R  = 64'h8000_0020;
    localparam logic [63:0] SD_AVAIL_R  = 64'h8000_0028;
    localparam logic [63:0] SD_BUF_LO   = 64'h8000_1000;
    localparam logic [63:0] SD_BUF_HI   = 64'h8000_1200;
    localparam int          LD_CYCLES    = 4;
    localparam int          SHORT_CYCLES = 3;
    localparam int          TIMEOUT      = 50;

    logic        CLOCK_50;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [2:0]  bus_read_type;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic [7:0]  key_ascii;
    logic        key_pressed;
    logic        interrupt_ack;
    logic [7:0]  sd_byte;
    logic        sd_byte_available;
    logic        sd_ready;
    logic [3:0]  interrupt_vector;
    logic [7:0]  uart_data;
    logic        uart_write;
    logic [31:0] sd_addr;
    logic        sd_rd_start;
    logic [7:0]  debug_led;

    logic [7:0]  sent_bytes [0:511];
    int          errors;
    int          checks;

    soc_bus dut_i (.*);

    always #5 CLOCK_50 = ~CLOCK_50;

    function automatic bit is_ram_address(input logic [63:0] addr);
        return addr >= RAM_LO && addr < RAM_HI;
    endfunction

    function automatic bit is_buffer_address(input logic [63:0] addr);
        return addr >= SD_BUF_LO && addr < SD_BUF_HI;
    endfunction

    // Region number shown on the low debug LEDs
    function automatic logic [3:0] region_code(input logic [63:0] addr);
        if (is_ram_address(addr)) begin
            return 4'd1;
        end
        case (addr)
            KEY_REG:    return 4'd2;
            UART_REG:   return 4'd3;
            SD_ADDR_R:  return 4'd4;
            SD_READ_R:  return 4'd5;
            SD_READY_R: return 4'd6;
            SD_AVAIL_R: return 4'd7;
            default:    return is_buffer_address(addr) ? 4'd8 : 4'd0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        next_cycle();
        bus_write_enable = 1'b0;
    endtask

    // Hold read_enable until done, then check data and latency
    task automatic bus_read(input logic [63:0] addr, input logic [2:0] ltype,
                            input logic [63:0] expected);
        int         n;
        int         want;
        logic       seen;
        logic [5:0] led_want;
        n    = 0;
        seen = 1'b0;
        want = (ltype == 3'd3 && is_ram_address(addr)) ? LD_CYCLES : SHORT_CYCLES;
        bus_address     = addr;
        bus_read_type   = ltype;
        bus_read_enable = 1'b1;
        while (seen !== 1'b1 && n < TIMEOUT) begin
            next_cycle();
            n    = n + 1;
            seen = bus_read_done;
        end
        bus_read_enable = 1'b0;
        if (seen !== 1'b1) begin
            $display("Timeout: read of address %h got no read_done within %0d cycles",
                     addr, TIMEOUT);
            errors++;
        end else begin
            checks += 3;
            if (bus_read_data !== expected) begin
                $display("[ERROR] bus_read_data at %h: got %h expected %h",
                         addr, bus_read_data, expected);
                errors++;
            end
            if (n != want) begin
                $display("[ERROR] read_done latency at %h: got %h expected %h", addr, n, want);
                errors++;
            end
            // Last access was this read, zero flag from its data
            led_want = {1'b0, expected == 64'd0, region_code(addr)};
            if (debug_led[5:0] !== led_want) begin
                $display("[ERROR] debug_led at %h: got %h expected %h",
                         addr, debug_led[5:0], led_want);
                errors++;
            end
        end
        next_cycle();
    endtask

    // Wait for one strobe, then make sure no second pulse follows
    task automatic check_strobe(input bit is_sd, input string name);
        int   n;
        int   pulses;
        logic level;
        n      = 0;
        pulses = 0;
        level  = 1'b0;
        while (level !== 1'b1 && n < TIMEOUT) begin
            next_cycle();
            n     = n + 1;
            level = is_sd ? sd_rd_start : uart_write;
        end
        if (level !== 1'b1) begin
            $display("Timeout: no %s pulse within %0d cycles", name, TIMEOUT);
            errors++;
        end else begin
            pulses = 1;
            repeat (4) begin
                next_cycle();
                level = is_sd ? sd_rd_start : uart_write;
                if (level === 1'b1) begin
                    pulses++;
                end
            end
            checks++;
            if (pulses != 1) begin
                $display("[ERROR] %s pulse count: got %h expected %h", name, pulses, 1);
                errors++;
            end
        end
    endtask

    // 512 byte strobes of two cycles each
    task automatic send_sector(input logic ready_level);
        for (int i = 0; i < 512; i++) begin
            sd_byte           = 8'($urandom);
            sent_bytes[i]     = sd_byte;
            sd_byte_available = 1'b1;
            next_cycle();
            sd_byte_available = 1'b0;
            next_cycle();
        end
        sd_ready = ready_level;
        next_cycle();
    endtask

    task automatic run_op(input string op, input logic [63:0] addr,
                          input logic [63:0] val, input logic [63:0] expected);
        logic [8:0] idx;
        if (op == "W") begin
            bus_write(addr, val);
            if (addr == UART_REG) begin
                check_strobe(1'b0, "uart_write");
                checks++;
                if (uart_data !== expected[7:0]) begin
                    $display("[ERROR] uart_data: got %h expected %h", uart_data, expected[7:0]);
                    errors++;
                end
            end else begin
                next_cycle();
                if (addr == SD_ADDR_R) begin
                    checks++;
                    if (sd_addr !== expected[31:0]) begin
                        $display("[ERROR] sd_addr: got %h expected %h", sd_addr, expected[31:0]);
                        errors++;
                    end
                end
            end
        end else if (op == "R") begin
            if (is_buffer_address(addr)) begin
                // Sector bytes come from this run's random data
                idx = 9'(addr - SD_BUF_LO);
                bus_read(addr, val[2:0], {56'd0, sent_bytes[idx]});
            end else begin
                bus_read(addr, val[2:0], expected);
            end
        end else if (op == "KEY" || op == "ACK") begin
            if (op == "KEY") begin
                key_ascii   = val[7:0];
                key_pressed = 1'b1;
            end else begin
                interrupt_ack = 1'b1;
            end
            next_cycle();
            key_pressed   = 1'b0;
            interrupt_ack = 1'b0;
            next_cycle();
            checks++;
            if (interrupt_vector !== expected[3:0]) begin
                $display("[ERROR] interrupt_vector after %s: got %h expected %h",
                         op, interrupt_vector, expected[3:0]);
                errors++;
            end
        end else if (op == "SDSTART") begin
            bus_write(addr, val);
            check_strobe(1'b1, "sd_rd_start");
        end else if (op == "SDFILL") begin
            send_sector(val[0]);
        end else begin
            $display("Unknown operation %s in the pattern file", op);
            errors++;
        end
    endtask

    initial begin
        int          fd;
        int          count;
        string       line;
        string       op;
        logic [63:0] addr;
        logic [63:0] val;
        logic [63:0] expected;
        errors            = 0;
        checks            = 0;
        CLOCK_50          = 1'b0;
        KEY0              = 1'b0;
        bus_address       = 64'd0;
        bus_write_data    = 64'd0;
        bus_write_enable  = 1'b0;
        bus_read_enable   = 1'b0;
        bus_read_type     = 3'd0;
        key_ascii         = 8'd0;
        key_pressed       = 1'b0;
        interrupt_ack     = 1'b0;
        sd_byte           = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        void'($urandom(32'haf5c));
        repeat (2) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        next_cycle();

        fd = $fopen("tb/bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file tb/bus_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                count = $fgets(line, fd);
                if (count > 0 && line.getc(0) != "#") begin
                    count = $sscanf(line, "%s %h %h %h", op, addr, val, expected);
                    if (count == 4) begin
                        run_op(op, addr, val, expected);
                    end
                end
            end
            $fclose(fd);
        end
        if (checks == 0) begin
            $display("No checks were run");
            errors++;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- soc_bus.f
source/soc_bus_pkg.sv
source/bus_decoder.sv
source/ram_port.sv
source/periph_regs.sv
source/read_return.sv
source/soc_bus.sv
tb/tb_soc_bus.sv

//--- Makefile
# Verilator build for the bus subsystem testbench

TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_soc_bus
FILELIST = soc_bus.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Test failed

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb/bus_patterns.txt
# op addr value expected (hex); R value is the load type, 0..6 = lb lh lw ld lbu lhu lwu
# W exp is uart_data or sd_addr, KEY/ACK exp is interrupt_vector, SDFILL value is sd_ready
W 1000 8badf00d 0
W 1004 12345678 0
R 1000 0 000000000000000d
R 1001 0 fffffffffffffff0
R 1001 4 00000000000000f0
R 1003 0 ffffffffffffff8b
R 1002 4 00000000000000ad
R 1000 1 fffffffffffff00d
R 1002 1 ffffffffffff8bad
R 1001 1 ffffffffffffadf0
R 1002 5 0000000000008bad
R 1003 1 000000000000008b
R 1000 2 ffffffff8badf00d
R 1001 2 00000000008badf0
R 1000 6 000000008badf00d
R 1000 3 123456788badf00d
W 1ff8 00000001 0
W 1ffc 80000000 0
R 1ff8 3 8000000000000001
R 1ffc 2 ffffffff80000000
KEY 80000000 41 1
R 80000000 0 0000000000000041
ACK 0 0 0
KEY 80000000 00 0
R 80000000 0 0000000000000000
W 80000008 1234565a 5a
W 80000010 deadbeef deadbeef
R 80000010 3 00000000deadbeef
SDSTART 80000018 0 0
R 80000028 0 0
R 80000020 0 0
SDFILL 0 1 0
R 80000028 0 1
R 80000020 0 1
R 80001000 4 0
R 80001001 4 0
R 800010ff 4 0
R 800011ff 4 0
SDSTART 80000018 0 0
R 80000028 0 0
R 00000000 2 0
R 80000030 3 0
